/* hw/rdma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field widths follow the RoCE stack command layout, trimmed to the
// fields this front end uses. Only READ and WRITE opcodes are decoded.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rdma_pkg;

  // Widths that carry a meaning
  typedef logic [4:0]  opcode_t;
  typedef logic [9:0]  qpn_t;
  typedef logic [47:0] vaddr_t;
  typedef logic [27:0] len_t;
  typedef logic [5:0]  pid_t;
  typedef logic [23:0] msn_t;
  typedef logic [31:0] cnt_t;

  // Send-queue opcodes
  localparam opcode_t RDMA_OP_READ  = 5'd0;
  localparam opcode_t RDMA_OP_WRITE = 5'd1;

  // User command on the send queue
  typedef struct packed {
    opcode_t opcode;
    qpn_t    qpn;
    logic    host;
    vaddr_t  vaddr;
    len_t    len;
    pid_t    pid;
  } sq_req_t;

  // Local memory command, same layout for read and write channels
  typedef struct packed {
    vaddr_t vaddr;
    len_t   len;
    logic   host;
    pid_t   pid;
  } mem_req_t;

  // ACK metadata from the network side
  typedef struct packed {
    logic is_nak;
    pid_t pid;
    msn_t msn;
  } ack_t;

endpackage

/* hw/rdma_flow_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit gate for the send queue, max_outstanding from 1 to 255.
// ACKs must arrive in msn order; anything else is counted and dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rdma_flow_ctrl #(
  parameter int unsigned max_outstanding = 4
) (
  input  logic             nclk,
  input  logic             nresetn,

  // User side of the send queue
  input  logic             sq_valid,
  output logic             sq_ready,

  // Toward the request engine
  output logic             eng_valid,
  input  logic             eng_ready,

  // ACK strobe, always accepted
  input  logic             ack_valid,
  input  rdma_pkg::ack_t   ack_data,

  // Debug counters
  output rdma_pkg::cnt_t   nak_count,
  output logic             nak_count_valid,
  output rdma_pkg::cnt_t   psn_drop_count,
  output logic             psn_drop_count_valid
);

  // Credit limit, 8 bits cover the full parameter range
  localparam logic [7:0] credit_max = 8'(max_outstanding);

  logic [7:0]       credits_q;
  logic [7:0]       credits_d;
  rdma_pkg::msn_t   exp_msn_q;
  logic             has_credit;
  logic             sq_fire;
  logic             ack_accept;
  logic             ack_drop;

  // Room for one more command
  assign has_credit = credits_q < credit_max;

  // Both directions masked while credits are exhausted
  assign eng_valid = sq_valid & has_credit;
  assign sq_ready  = eng_ready & has_credit;
  assign sq_fire   = sq_valid & sq_ready;

  // In-order check, only meaningful with credits in flight
  assign ack_accept = ack_valid && (credits_q != 8'd0) && (ack_data.msn == exp_msn_q);
  assign ack_drop   = ack_valid && !ack_accept;

  // Handshake and ACK may land in the same cycle
  always_comb begin
    credits_d = credits_q;
    if (sq_fire) begin
      credits_d = credits_d + 8'd1;
    end
    if (ack_accept) begin
      credits_d = credits_d - 8'd1;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      credits_q <= 8'd0;
      exp_msn_q <= '0;
    end else begin
      credits_q <= credits_d;
      // Wraps modulo 2^24 by width
      if (ack_accept) begin
        exp_msn_q <= exp_msn_q + rdma_pkg::msn_t'(1);
      end
    end
  end

  // Counters plus pulse one cycle behind the increment
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      nak_count            <= '0;
      nak_count_valid      <= 1'b0;
      psn_drop_count       <= '0;
      psn_drop_count_valid <= 1'b0;
    end else begin
      nak_count_valid      <= ack_accept & ack_data.is_nak;
      psn_drop_count_valid <= ack_drop;
      // NAK still returns its credit above
      if (ack_accept && ack_data.is_nak) begin
        nak_count <= nak_count + rdma_pkg::cnt_t'(1);
      end
      if (ack_drop) begin
        psn_drop_count <= psn_drop_count + rdma_pkg::cnt_t'(1);
      end
    end
  end

endmodule

/* hw/rdma_req_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-entry request engine, one command in flight at a time.
// Opcodes other than READ and WRITE are consumed with no request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rdma_req_engine (
  input  logic                nclk,
  input  logic                nresetn,

  // Command in, already credit gated
  input  logic                eng_valid,
  output logic                eng_ready,
  input  rdma_pkg::sq_req_t   sq_data,

  // Memory read commands, fetch payload for a WRITE
  output logic                rd_req_valid,
  input  logic                rd_req_ready,
  output rdma_pkg::mem_req_t  rd_req_data,

  // Memory write commands, place data for a READ
  output logic                wr_req_valid,
  input  logic                wr_req_ready,
  output rdma_pkg::mem_req_t  wr_req_data
);

  typedef enum logic [1:0] {
    idle,
    issue_rd,
    issue_wr
  } state_t;

  state_t              state_q;
  rdma_pkg::mem_req_t  req_q;
  logic                cmd_fire;

  // Takes a command only with nothing pending
  assign eng_ready = (state_q == idle);
  assign cmd_fire  = eng_valid & eng_ready;

  // Payload register, loaded on every accepted command
  always_ff @(posedge nclk) begin
    if (cmd_fire) begin
      req_q.vaddr <= sq_data.vaddr;
      req_q.len   <= sq_data.len;
      req_q.host  <= sq_data.host;
      req_q.pid   <= sq_data.pid;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state_q <= idle;
    end else begin
      case (state_q)
        idle: begin
          if (cmd_fire) begin
            // WRITE reads local memory, READ writes it
            if (sq_data.opcode == rdma_pkg::RDMA_OP_WRITE) begin
              state_q <= issue_rd;
            end else if (sq_data.opcode == rdma_pkg::RDMA_OP_READ) begin
              state_q <= issue_wr;
            end
            // Unknown opcode dropped, stay idle
          end
        end
        issue_rd: begin
          if (rd_req_ready) begin
            state_q <= idle;
          end
        end
        issue_wr: begin
          if (wr_req_ready) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // Valid straight from state, data held in req_q until taken
  assign rd_req_valid = (state_q == issue_rd);
  assign wr_req_valid = (state_q == issue_wr);
  assign rd_req_data  = req_q;
  assign wr_req_data  = req_q;

endmodule

/* hw/rdma_stack.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Send-queue front end, no packet path or QP setup behind it.
// ACKs have no ready, every strobe is consumed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rdma_stack #(
  parameter int unsigned max_outstanding = 4
) (
  input  logic                nclk,
  input  logic                nresetn,

  // User send queue
  input  logic                sq_valid,
  output logic                sq_ready,
  input  rdma_pkg::sq_req_t   sq_data,

  // Memory read commands
  output logic                rd_req_valid,
  input  logic                rd_req_ready,
  output rdma_pkg::mem_req_t  rd_req_data,

  // Memory write commands
  output logic                wr_req_valid,
  input  logic                wr_req_ready,
  output rdma_pkg::mem_req_t  wr_req_data,

  // Returned ACK metadata
  input  logic                ack_valid,
  input  rdma_pkg::ack_t      ack_data,

  // Debug
  output rdma_pkg::cnt_t      nak_count,
  output logic                nak_count_valid,
  output rdma_pkg::cnt_t      psn_drop_count,
  output logic                psn_drop_count_valid
);

  // Gated command handshake between the two blocks
  logic eng_valid;
  logic eng_ready;

  rdma_flow_ctrl #(
    .max_outstanding (max_outstanding)
  ) flow_ctrl_i (
    .nclk                 (nclk),
    .nresetn              (nresetn),
    .sq_valid             (sq_valid),
    .sq_ready             (sq_ready),
    .eng_valid            (eng_valid),
    .eng_ready            (eng_ready),
    .ack_valid            (ack_valid),
    .ack_data             (ack_data),
    .nak_count            (nak_count),
    .nak_count_valid      (nak_count_valid),
    .psn_drop_count       (psn_drop_count),
    .psn_drop_count_valid (psn_drop_count_valid)
  );

  // Command data goes straight in, only valid/ready are gated
  rdma_req_engine req_engine_i (
    .nclk         (nclk),
    .nresetn      (nresetn),
    .eng_valid    (eng_valid),
    .eng_ready    (eng_ready),
    .sq_data      (sq_data),
    .rd_req_valid (rd_req_valid),
    .rd_req_ready (rd_req_ready),
    .rd_req_data  (rd_req_data),
    .wr_req_valid (wr_req_valid),
    .wr_req_ready (wr_req_ready),
    .wr_req_data  (wr_req_data)
  );

endmodule

/* tests/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10 ns clock, active-low reset held for the first 3 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock (
  output logic nclk,
  output logic nresetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    nclk = 1'b0;
    forever #5 nclk = ~nclk;
  end

  // Released just after the third edge, like any other driven input
  initial begin
    nresetn = 1'b0;
    repeat (3) @(posedge nclk);
    #1 nresetn = 1'b1;
  end

endmodule

/* tests/rdma_stack_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound into rdma_stack; models credits and expected msn from ports.
// fail_count is read by the testbench after any assertion failure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rdma_stack_checker #(
  parameter int unsigned max_outstanding = 4
) (
  input logic                nclk,
  input logic                nresetn,
  input logic                sq_valid,
  input logic                sq_ready,
  input rdma_pkg::sq_req_t   sq_data,
  input logic                rd_req_valid,
  input logic                rd_req_ready,
  input rdma_pkg::mem_req_t  rd_req_data,
  input logic                wr_req_valid,
  input logic                wr_req_ready,
  input rdma_pkg::mem_req_t  wr_req_data,
  input logic                ack_valid,
  input rdma_pkg::ack_t      ack_data,
  input rdma_pkg::cnt_t      nak_count,
  input logic                nak_count_valid,
  input rdma_pkg::cnt_t      psn_drop_count,
  input logic                psn_drop_count_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned         fail_count = 0;
  int unsigned         credits_m;
  rdma_pkg::msn_t      exp_msn_m;
  rdma_pkg::cnt_t      nak_m;
  rdma_pkg::cnt_t      drop_m;
  logic                nak_pulse_m;
  logic                drop_pulse_m;
  logic                fire_q;
  logic                op_wr_q;
  logic                op_rd_q;
  rdma_pkg::mem_req_t  req_m;
  logic                sq_fire;
  logic                ack_ok;

  assign sq_fire = sq_valid && sq_ready;
  // In order and with something outstanding
  assign ack_ok  = ack_valid && (credits_m != 0) && (ack_data.msn == exp_msn_m);

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      credits_m    <= 0;
      exp_msn_m    <= '0;
      nak_m        <= '0;
      drop_m       <= '0;
      nak_pulse_m  <= 1'b0;
      drop_pulse_m <= 1'b0;
      fire_q       <= 1'b0;
      op_wr_q      <= 1'b0;
      op_rd_q      <= 1'b0;
    end else begin
      credits_m    <= credits_m + (sq_fire ? 1 : 0) - (ack_ok ? 1 : 0);
      exp_msn_m    <= ack_ok ? exp_msn_m + 24'd1 : exp_msn_m;
      nak_m        <= (ack_ok && ack_data.is_nak) ? nak_m + 32'd1 : nak_m;
      drop_m       <= (ack_valid && !ack_ok) ? drop_m + 32'd1 : drop_m;
      nak_pulse_m  <= ack_ok && ack_data.is_nak;
      drop_pulse_m <= ack_valid && !ack_ok;
      fire_q       <= sq_fire;
      // WRITE fetches payload, READ places data
      op_wr_q      <= sq_data.opcode == rdma_pkg::RDMA_OP_WRITE;
      op_rd_q      <= sq_data.opcode == rdma_pkg::RDMA_OP_READ;
    end
  end

  // Memory command expected one cycle after the handshake
  always_ff @(posedge nclk) begin
    if (sq_fire) begin
      req_m.vaddr <= sq_data.vaddr;
      req_m.len   <= sq_data.len;
      req_m.host  <= sq_data.host;
      req_m.pid   <= sq_data.pid;
    end
  end

  a_credit_gate: assert property (@(posedge nclk) disable iff (!nresetn)
    sq_ready |-> credits_m < max_outstanding)
    else begin fail_count = fail_count + 1; $error("sq_ready high with no credit left"); end

  a_rd_issue: assert property (@(posedge nclk) disable iff (!nresetn)
    fire_q && op_wr_q |-> rd_req_valid && rd_req_data == req_m)
    else begin fail_count = fail_count + 1; $error("WRITE gave no matching read command"); end

  a_wr_issue: assert property (@(posedge nclk) disable iff (!nresetn)
    fire_q && op_rd_q |-> wr_req_valid && wr_req_data == req_m)
    else begin fail_count = fail_count + 1; $error("READ gave no matching write command"); end

  a_no_issue: assert property (@(posedge nclk) disable iff (!nresetn)
    fire_q && !op_wr_q && !op_rd_q |-> !rd_req_valid && !wr_req_valid)
    else begin fail_count = fail_count + 1; $error("unknown opcode raised a request"); end

  a_rd_hold: assert property (@(posedge nclk) disable iff (!nresetn)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_data))
    else begin fail_count = fail_count + 1; $error("read command changed before ready"); end

  a_wr_hold: assert property (@(posedge nclk) disable iff (!nresetn)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req_data))
    else begin fail_count = fail_count + 1; $error("write command changed before ready"); end

  a_busy: assert property (@(posedge nclk) disable iff (!nresetn)
    rd_req_valid || wr_req_valid |-> !sq_ready)
    else begin fail_count = fail_count + 1; $error("sq_ready high with a request pending"); end

  a_nak_count: assert property (@(posedge nclk) disable iff (!nresetn)
    nak_count == nak_m && nak_count_valid == nak_pulse_m)
    else begin fail_count = fail_count + 1; $error("nak_count or its pulse is off"); end

  a_drop_count: assert property (@(posedge nclk) disable iff (!nresetn)
    psn_drop_count == drop_m && psn_drop_count_valid == drop_pulse_m)
    else begin fail_count = fail_count + 1; $error("psn_drop_count or its pulse is off"); end

endmodule

bind rdma_stack rdma_stack_checker #(
  .max_outstanding (max_outstanding)
) checker_i (
  .nclk                 (nclk),
  .nresetn              (nresetn),
  .sq_valid             (sq_valid),
  .sq_ready             (sq_ready),
  .sq_data              (sq_data),
  .rd_req_valid         (rd_req_valid),
  .rd_req_ready         (rd_req_ready),
  .rd_req_data          (rd_req_data),
  .wr_req_valid         (wr_req_valid),
  .wr_req_ready         (wr_req_ready),
  .wr_req_data          (wr_req_data),
  .ack_valid            (ack_valid),
  .ack_data             (ack_data),
  .nak_count            (nak_count),
  .nak_count_valid      (nak_count_valid),
  .psn_drop_count       (psn_drop_count),
  .psn_drop_count_valid (psn_drop_count_valid)
);

/* tests/rdma_stack_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drives rdma_stack with max_outstanding 4; memory ready is random.
// Expects dut_i.checker_i from the bind in rdma_stack_checker.sv.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rdma_stack_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] seed = 32'h5e21_68ed;

  logic                nclk;
  logic                nresetn;
  logic                sq_valid;
  logic                sq_ready;
  rdma_pkg::sq_req_t   sq_data;
  logic                rd_req_valid;
  logic                rd_req_ready;
  rdma_pkg::mem_req_t  rd_req_data;
  logic                wr_req_valid;
  logic                wr_req_ready;
  rdma_pkg::mem_req_t  wr_req_data;
  logic                ack_valid;
  rdma_pkg::ack_t      ack_data;
  rdma_pkg::cnt_t      nak_count;
  logic                nak_count_valid;
  rdma_pkg::cnt_t      psn_drop_count;
  logic                psn_drop_count_valid;

  logic [31:0]         stim_rng = seed;
  bit                  ready_en = 1'b0;
  int unsigned         taken_count = 0;
  int unsigned         credits_used = 0;
  rdma_pkg::cnt_t      naks_exp = '0;
  rdma_pkg::cnt_t      drops_exp = '0;
  rdma_pkg::msn_t      next_msn = '0;
  rdma_pkg::mem_req_t  rd_exp[$];
  rdma_pkg::mem_req_t  wr_exp[$];

  tb_clock clock_i (.nclk(nclk), .nresetn(nresetn));

  rdma_stack #(.max_outstanding(4)) dut_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
    $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, want);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  // Fields a memory command must carry for this user command
  function automatic rdma_pkg::mem_req_t mem_fields(input rdma_pkg::sq_req_t c);
    rdma_pkg::mem_req_t m;
    m.vaddr = c.vaddr;
    m.len   = c.len;
    m.host  = c.host;
    m.pid   = c.pid;
    return m;
  endfunction

  // Memory side back-pressure with roughly half the cycles ready
  initial begin
    logic [31:0] ready_rng;
    ready_rng    = seed;
    rd_req_ready = 1'b0;
    wr_req_ready = 1'b0;
    forever begin
      @(posedge nclk);
      #1;
      ready_rng    = lcg_next(ready_rng);
      rd_req_ready = ready_en & ready_rng[20];
      wr_req_ready = ready_en & ready_rng[27];
    end
  end

  // Handshake monitor at mid-cycle where everything is settled
  always @(negedge nclk) begin
    rdma_pkg::mem_req_t want;
    if (nresetn) begin
      if (dut_i.checker_i.fail_count != 0) begin
        report_problem("bound checker assertion failed");
      end
      if (sq_valid && sq_ready) begin
        taken_count++;
        if (sq_data.opcode == rdma_pkg::RDMA_OP_WRITE) rd_exp.push_back(mem_fields(sq_data));
        if (sq_data.opcode == rdma_pkg::RDMA_OP_READ) wr_exp.push_back(mem_fields(sq_data));
      end
      if (rd_req_valid && rd_req_ready) begin
        if (rd_exp.size() == 0) report_problem("read command with no WRITE behind it");
        want = rd_exp.pop_front();
        assert (rd_req_data == want)
          else report_mismatch("rd_req_data", 128'(rd_req_data), 128'(want));
      end
      if (wr_req_valid && wr_req_ready) begin
        if (wr_exp.size() == 0) report_problem("write command with no READ behind it");
        want = wr_exp.pop_front();
        assert (wr_req_data == want)
          else report_mismatch("wr_req_data", 128'(wr_req_data), 128'(want));
      end
    end
  end

  task automatic make_cmd(input rdma_pkg::opcode_t op, output rdma_pkg::sq_req_t c);
    stim_rng = lcg_next(stim_rng);
    c.opcode = op;
    c.qpn    = stim_rng[9:0];
    c.pid    = stim_rng[17:12];
    c.host   = stim_rng[31];
    stim_rng = lcg_next(stim_rng);
    c.vaddr  = {stim_rng[15:0], lcg_next(stim_rng)};
    c.len    = stim_rng[31:4];
  endtask

  task automatic send_cmd(input rdma_pkg::sq_req_t c);
    int unsigned n;
    @(posedge nclk);
    #1;
    sq_valid = 1'b1;
    sq_data  = c;
    n = 0;
    do begin
      @(negedge nclk);
      n++;
      if (!sq_ready && n > 200) report_problem("send queue never took the command");
    end while (!sq_ready);
    @(posedge nclk);
    #1;
    sq_valid = 1'b0;
    credits_used++;
  endtask

  task automatic wait_count_pulse(input bit nak_side);
    int unsigned n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge nclk);
      n++;
      seen = nak_side ? nak_count_valid : psn_drop_count_valid;
      if (!seen && n > 4) report_problem("counter valid pulse never came");
    end
  endtask

  // Expected outcome comes from the credit and msn rule
  task automatic ack_and_check(input logic is_nak, input rdma_pkg::msn_t msn);
    bit accept;
    accept = (credits_used != 0) && (msn == next_msn);
    @(posedge nclk);
    #1;
    ack_valid       = 1'b1;
    ack_data.is_nak = is_nak;
    ack_data.pid    = stim_rng[5:0];
    ack_data.msn    = msn;
    @(posedge nclk);
    #1;
    ack_valid = 1'b0;
    if (accept) begin
      credits_used--;
      next_msn++;
      if (is_nak) begin
        naks_exp++;
        wait_count_pulse(1'b1);
        assert (nak_count == naks_exp)
          else report_mismatch("nak_count", 128'(nak_count), 128'(naks_exp));
      end
    end else begin
      drops_exp++;
      wait_count_pulse(1'b0);
      assert (psn_drop_count == drops_exp)
        else report_mismatch("psn_drop_count", 128'(psn_drop_count), 128'(drops_exp));
    end
  endtask

  task automatic wait_drained();
    int unsigned n;
    n = 0;
    while (rd_exp.size() != 0 || wr_exp.size() != 0 || rd_req_valid || wr_req_valid) begin
      @(negedge nclk);
      n++;
      if (n > 300) report_problem("memory commands never drained");
    end
  endtask

  initial begin
    rdma_pkg::sq_req_t cmd;
    int unsigned n;
    int i;
    sq_valid  = 1'b0;
    sq_data   = '0;
    ack_valid = 1'b0;
    ack_data  = '0;
    n = 0;
    while (nresetn !== 1'b1) begin
      @(posedge nclk);
      n++;
      if (n > 20) report_problem("reset was never released");
    end

    // Quiet outputs right after reset
    @(negedge nclk);
    assert (!rd_req_valid) else report_mismatch("rd_req_valid", 128'(rd_req_valid), 128'd0);
    assert (!wr_req_valid) else report_mismatch("wr_req_valid", 128'(wr_req_valid), 128'd0);
    assert (!nak_count_valid)
      else report_mismatch("nak_count_valid", 128'(nak_count_valid), 128'd0);
    assert (!psn_drop_count_valid)
      else report_mismatch("psn_drop_count_valid", 128'(psn_drop_count_valid), 128'd0);
    assert (nak_count == '0) else report_mismatch("nak_count", 128'(nak_count), 128'd0);
    assert (psn_drop_count == '0)
      else report_mismatch("psn_drop_count", 128'(psn_drop_count), 128'd0);
    assert (sq_ready) else report_mismatch("sq_ready", 128'(sq_ready), 128'd1);

    // Matching msn with nothing outstanding is dropped
    ack_and_check(1'b0, next_msn);

    // WRITE held against a stalled read channel
    make_cmd(rdma_pkg::RDMA_OP_WRITE, cmd);
    send_cmd(cmd);
    for (i = 0; i < 8; i++) begin
      @(negedge nclk);
      assert (rd_req_valid) else report_mismatch("rd_req_valid", 128'(rd_req_valid), 128'd1);
      assert (!sq_ready) else report_mismatch("sq_ready", 128'(sq_ready), 128'd0);
    end
    ready_en = 1'b1;

    // READ, an unknown opcode, then a last WRITE uses up all credits
    make_cmd(rdma_pkg::RDMA_OP_READ, cmd);
    send_cmd(cmd);
    make_cmd(5'd9, cmd);
    send_cmd(cmd);
    make_cmd(rdma_pkg::RDMA_OP_WRITE, cmd);
    send_cmd(cmd);
    wait_drained();

    // Fifth command has to sit with no ACK coming back
    make_cmd(rdma_pkg::RDMA_OP_READ, cmd);
    @(posedge nclk);
    #1;
    sq_valid = 1'b1;
    sq_data  = cmd;
    for (i = 0; i < 16; i++) begin
      @(negedge nclk);
      assert (!sq_ready) else report_mismatch("sq_ready", 128'(sq_ready), 128'd0);
    end
    @(posedge nclk);
    #1;
    sq_valid = 1'b0;
    assert (taken_count == 4) else report_mismatch("taken_count", 128'(taken_count), 128'd4);

    // Out of order, plain ACK, then NAK
    ack_and_check(1'b0, next_msn + 24'd5);
    ack_and_check(1'b0, next_msn);
    ack_and_check(1'b1, next_msn);

    // Command and matching ACK land on the same edge
    make_cmd(rdma_pkg::RDMA_OP_READ, cmd);
    @(posedge nclk);
    #1;
    sq_valid        = 1'b1;
    sq_data         = cmd;
    ack_valid       = 1'b1;
    ack_data.is_nak = 1'b0;
    ack_data.msn    = next_msn;
    @(negedge nclk);
    assert (sq_ready) else report_mismatch("sq_ready", 128'(sq_ready), 128'd1);
    @(posedge nclk);
    #1;
    sq_valid  = 1'b0;
    ack_valid = 1'b0;
    next_msn++;

    // Back at the limit with the engine idle
    make_cmd(rdma_pkg::RDMA_OP_READ, cmd);
    send_cmd(cmd);
    make_cmd(rdma_pkg::RDMA_OP_WRITE, cmd);
    send_cmd(cmd);
    wait_drained();

    // Random mix of commands and good or bad ACKs
    for (i = 0; i < 80; i++) begin
      stim_rng = lcg_next(stim_rng);
      if (credits_used < 4 && stim_rng[3]) begin
        make_cmd(stim_rng[6:5] == 2'd0 ? 5'd9 :
                 (stim_rng[7] ? rdma_pkg::RDMA_OP_WRITE : rdma_pkg::RDMA_OP_READ), cmd);
        send_cmd(cmd);
      end else if (stim_rng[10:9] == 2'd0) begin
        ack_and_check(stim_rng[12], next_msn + 24'd3);
      end else begin
        ack_and_check(stim_rng[12], next_msn);
      end
    end
    wait_drained();

    if (dut_i.checker_i.fail_count != 0) begin
      report_problem("bound checker assertion failed");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* build.f */
hw/rdma_pkg.sv
hw/rdma_flow_ctrl.sv
hw/rdma_req_engine.sv
hw/rdma_stack.sv
tests/tb_clock.sv
tests/rdma_stack_checker.sv
tests/rdma_stack_tb.sv

/* Makefile */
# Verilator build and run of the RDMA send-queue testbench

SIM := obj_dir/Vrdma_stack_tb

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the list itself changes
$(SIM): build.f $(shell cat build.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module rdma_stack_tb -f build.f -o Vrdma_stack_tb

# Error limit raised so the testbench can print its own verdict
run: $(SIM)
	-$(SIM) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test passed" sim.log || (echo "No verdict in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
